//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = main_board_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard common/*.sv hw/*.sv hw/main_bus/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- common/board_pkg.sv
// ###################
// cabinet inputs and protection chip types
// used by the I/O ports, the protection unit and the testbench
// ###################

package board_pkg;

    // offsets inside the cab and sys pages
    localparam logic [1:0] CAB_P2   = 2'd0;
    localparam logic [1:0] CAB_P1   = 2'd1;
    localparam logic [1:0] SYS_COIN = 2'd0;
    localparam logic [1:0] SYS_DIPA = 2'd1;
    localparam logic [1:0] SYS_DIPB = 2'd2;

    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic [5:0] joy1;
        logic [5:0] joy2;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
    } cab_in_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } prot_bytes_t;

    // written a byte at a time, divided as a word
    typedef union packed {
        logic [15:0] word;
        prot_bytes_t bytes;
    } prot_word_u;

endpackage

//--- common/main_pkg.sv
// ###################
// main CPU bus types and the address map
// shared by the bus sequencer, the top level and the testbench
// ###################

package main_pkg;

    localparam int RAM_AW = 11;
    localparam int ROM_AW = 17;
    localparam int BANK_W = 3;

    // address map, compared against the upper address bits
    localparam logic [1:0] ROM_BANKED   = 2'b01;      // A15:14, 4000-7fff
    localparam logic [2:0] GFX_BASE     = 3'b001;     // A15:13, 2000-3fff
    localparam logic [4:0] RAM_BASE     = 5'b00011;   // A15:11, 1800-1fff
    localparam logic [4:0] PAL_BASE     = 5'b00010;   // A15:11, 1000-17ff
    localparam logic [4:0] IO_PAGES     = 5'b00001;   // A15:11, 0800-0fff
    localparam logic [7:0] CFG_BASE     = 8'h00;      // A15:8
    localparam logic [12:0] VID_CFG_BASE = 13'h1000;

    // pages inside the I/O window, selected by A10:8
    localparam logic [2:0] PG_SND  = 3'd0;
    localparam logic [2:0] PG_CAB  = 3'd2;
    localparam logic [2:0] PG_SYS  = 3'd3;
    localparam logic [2:0] PG_BANK = 3'd4;
    localparam logic [2:0] PG_PROT = 3'd5;
    localparam logic [2:0] PG_WDOG = 3'd6;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rnw;
    } bus_req_t;

    typedef struct packed {
        logic [7:0] rdata;   // ff on writes
    } bus_rsp_t;

    typedef enum logic [3:0] {
        reg_rom, reg_ram, reg_pal, reg_gfx, reg_cfg,
        reg_cab, reg_sys, reg_bank, reg_prot, reg_none
    } region_e;

    typedef struct packed {
        logic [12:0] addr;
        logic        pal;
        logic        we;
        logic [7:0]  wdata;
    } vid_req_t;

endpackage

//--- hw/cabinet_io.sv
// ###################
// cabinet read ports: joysticks, coin/start/service and DIP switches
// one registered byte per strobe, shared by the cab and sys pages
// ###################
`timescale 1ns/10ps

module cabinet_io (
    input  logic                clk,
    input  logic                rst,
    input  logic                cab_cs,
    input  logic                sys_cs,
    input  logic [1:0]          sel,
    input  board_pkg::cab_in_t  cab,
    output logic [7:0]          dout
);
    import board_pkg::*;

    logic [5:0] joy;
    logic [7:0] cab_val, sys_val;

    always_comb begin
        joy = cab.joy2;
        case ({1'b0, sel[0]})
            CAB_P1: joy = cab.joy1;
            CAB_P2: joy = cab.joy2;
            default: joy = cab.joy2;
        endcase
    end

    // the board swaps the two direction pairs
    assign cab_val = {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};

    always_comb begin
        case (sel)
            SYS_COIN: sys_val = {3'b111, cab.start, cab.service, cab.coin};
            SYS_DIPA: sys_val = cab.dipsw_a;
            SYS_DIPB: sys_val = cab.dipsw_b;
            default:  sys_val = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= 8'hff;
        end else if (cab_cs) begin
            dout <= cab_val;
        end else if (sys_cs) begin
            dout <= sys_val;
        end
    end

endmodule

//--- hw/main_board.sv
// ###################
// main CPU side of the board, driven by an external bus master
// connects the bus glue to RAM, cabinet ports and protection chip
// ###################
`timescale 1ns/10ps

module main_board (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    input  main_pkg::bus_req_t          req,
    output logic                        req_ready,
    output logic                        rsp_valid,
    output main_pkg::bus_rsp_t          rsp,
    input  logic                        rsp_ready,
    output logic                        rom_cs,
    output logic [main_pkg::ROM_AW-1:0] rom_addr,
    input  logic [7:0]                  rom_data,
    input  logic                        rom_ok,
    output logic                        vid_cs,
    output main_pkg::vid_req_t          vid,
    input  logic [7:0]                  vid_dout,
    input  board_pkg::cab_in_t          cab,
    input  logic                        vblank,
    input  logic                        pause,
    input  logic                        irq_ack,
    output logic                        irq_n
);
    import main_pkg::*;

    logic        ram_cs, ram_we, cab_cs, sys_cs, prot_cs, prot_we;
    logic [7:0]  ram_dout, cab_dout, prot_dout;
    logic [15:0] bus_addr;
    logic [7:0]  bus_wdata;

    main_bus main_bus_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .vid_cs    (vid_cs),
        .vid       (vid),
        .vid_dout  (vid_dout),
        .vblank    (vblank),
        .pause     (pause),
        .irq_ack   (irq_ack),
        .irq_n     (irq_n),
        .ram_cs    (ram_cs),
        .ram_we    (ram_we),
        .ram_dout  (ram_dout),
        .cab_cs    (cab_cs),
        .sys_cs    (sys_cs),
        .cab_dout  (cab_dout),
        .prot_cs   (prot_cs),
        .prot_we   (prot_we),
        .prot_dout (prot_dout),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata)
    );

    work_ram work_ram_inst (
        .clk    (clk),
        .ram_cs (ram_cs),
        .ram_we (ram_we),
        .addr   (bus_addr[RAM_AW-1:0]),
        .wdata  (bus_wdata),
        .rdata  (ram_dout)
    );

    cabinet_io cabinet_io_inst (
        .clk    (clk),
        .rst    (rst),
        .cab_cs (cab_cs),
        .sys_cs (sys_cs),
        .sel    (bus_addr[1:0]),
        .cab    (cab),
        .dout   (cab_dout)
    );

    prot_math prot_math_inst (
        .clk     (clk),
        .rst     (rst),
        .prot_cs (prot_cs),
        .prot_we (prot_we),
        .addr    (bus_addr[2:0]),
        .wdata   (bus_wdata),
        .rdata   (prot_dout)
    );

endmodule

//--- hw/main_bus/main_bus.sv
// ###################
// main CPU bus glue: accepts one access at a time, decodes it,
// strobes the device or waits on ROM, and returns a registered byte
// ###################
`timescale 1ns/10ps

module main_bus (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_valid,
    input  main_pkg::bus_req_t              req,
    output logic                            req_ready,
    output logic                            rsp_valid,
    output main_pkg::bus_rsp_t              rsp,
    input  logic                            rsp_ready,
    output logic                            rom_cs,
    output logic [main_pkg::ROM_AW-1:0]     rom_addr,
    input  logic [7:0]                      rom_data,
    input  logic                            rom_ok,
    output logic                            vid_cs,
    output main_pkg::vid_req_t              vid,
    input  logic [7:0]                      vid_dout,
    input  logic                            vblank,
    input  logic                            pause,
    input  logic                            irq_ack,
    output logic                            irq_n,
    output logic                            ram_cs,
    output logic                            ram_we,
    input  logic [7:0]                      ram_dout,
    output logic                            cab_cs,
    output logic                            sys_cs,
    input  logic [7:0]                      cab_dout,
    output logic                            prot_cs,
    output logic                            prot_we,
    input  logic [7:0]                      prot_dout,
    output logic [15:0]                     bus_addr,
    output logic [7:0]                      bus_wdata
);
    import main_pkg::*;

    typedef enum logic [1:0] {st_idle, st_data, st_rom, st_rsp} state_e;

    state_e              state;
    region_e             region, region_q;
    logic                rnw_q;
    logic                accept;
    logic [BANK_W-1:0]   bank;
    logic [3:0]          rom_page;
    logic                vblank_l, irq_q;

    always_comb begin
        region = reg_none;
        if (req.addr[15]) begin
            if (req.rnw) region = reg_rom;
        end else if (req.addr[15:14] == ROM_BANKED) begin
            if (req.rnw) region = reg_rom;
        end else if (req.addr[15:13] == GFX_BASE) begin
            region = reg_gfx;
        end else if (req.addr[15:11] == RAM_BASE) begin
            region = reg_ram;
        end else if (req.addr[15:11] == PAL_BASE) begin
            region = reg_pal;
        end else if (req.addr[15:8] == CFG_BASE) begin
            region = reg_cfg;
        end else if (req.addr[15:11] == IO_PAGES) begin
            case (req.addr[10:8])
                PG_CAB:  region = req.rnw ? reg_cab : reg_none;
                PG_SYS:  region = req.rnw ? reg_sys : reg_none;
                PG_BANK: region = req.rnw ? reg_none : reg_bank;
                PG_PROT: region = reg_prot;
                PG_SND, PG_WDOG: region = reg_none;   // accepted, no effect
                default: region = reg_none;
            endcase
        end
    end

    assign accept    = req_valid && req_ready;
    assign req_ready = state == st_idle;
    assign bus_addr  = req.addr;
    assign bus_wdata = req.wdata;

    // device strobes last exactly the acceptance cycle
    assign ram_cs  = accept && region == reg_ram;
    assign ram_we  = !req.rnw;
    assign cab_cs  = accept && region == reg_cab;
    assign sys_cs  = accept && region == reg_sys;
    assign prot_cs = accept && region == reg_prot;
    assign prot_we = !req.rnw;
    assign vid_cs  = accept && (region == reg_pal || region == reg_gfx || region == reg_cfg);

    always_comb begin
        vid.pal   = region == reg_pal;
        vid.we    = !req.rnw;
        vid.wdata = req.wdata;
        case (region)
            reg_cfg: vid.addr = VID_CFG_BASE | {5'd0, req.addr[7:0]};
            reg_gfx: vid.addr = {~req.addr[12], req.addr[11:0]};
            default: vid.addr = {2'b00, req.addr[10:0]};
        endcase
    end

    assign rom_page = {1'b0, bank} + 4'd4;   // banked pages start at 0x08000

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            rsp_valid <= 1'b0;
            rom_cs    <= 1'b0;
            bank      <= '0;
        end else begin
            case (state)
                st_idle: if (accept) begin
                    if (region == reg_rom) begin
                        rom_cs <= 1'b1;
                        state  <= st_rom;
                    end else begin
                        state  <= st_data;
                    end
                    if (region == reg_bank) bank <= req.wdata[BANK_W-1:0];
                end
                st_data: begin
                    rsp_valid <= 1'b1;
                    state     <= st_rsp;
                end
                st_rom: if (rom_ok) begin
                    rom_cs    <= 1'b0;
                    rsp_valid <= 1'b1;
                    state     <= st_rsp;
                end
                st_rsp: if (rsp_ready) begin
                    rsp_valid <= 1'b0;
                    state     <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            region_q <= region;
            rnw_q    <= req.rnw;
            rom_addr <= req.addr[15] ? {2'b00, req.addr[14:0]} : {rom_page, req.addr[12:0]};
        end
        if (state == st_rom && rom_ok) rsp.rdata <= rom_data;
        if (state == st_data) begin
            if (!rnw_q) begin
                rsp.rdata <= 8'hff;
            end else begin
                case (region_q)
                    reg_ram:                   rsp.rdata <= ram_dout;
                    reg_pal, reg_gfx, reg_cfg: rsp.rdata <= vid_dout;
                    reg_cab, reg_sys:          rsp.rdata <= cab_dout;
                    reg_prot:                  rsp.rdata <= prot_dout;
                    default:                   rsp.rdata <= 8'hff;
                endcase
            end
        end
    end

    // vblank edge latch, ack has priority
    always_ff @(posedge clk) begin
        if (rst) begin
            vblank_l <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            vblank_l <= vblank;
            if (irq_ack) begin
                irq_q <= 1'b0;
            end else if (vblank && !vblank_l && !pause) begin
                irq_q <= 1'b1;
            end
        end
    end

    assign irq_n = ~irq_q;

    // no device strobe while the ROM wait runs
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ram_cs, cab_cs, sys_cs, prot_cs, vid_cs, rom_cs}));

    a_rsp_busy: assert property (@(posedge clk) disable iff (rst)
        !(rsp_valid && req_ready));

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(rom_cs) |-> $past(rom_ok));

endmodule

//--- hw/main_bus/work_ram.sv
// ###################
// 2 KB work RAM for the main CPU
// single port, read data registered on every strobe
// ###################
`timescale 1ns/10ps

module work_ram (
    input  logic                        clk,
    input  logic                        ram_cs,
    input  logic                        ram_we,
    input  logic [main_pkg::RAM_AW-1:0] addr,
    input  logic [7:0]                  wdata,
    output logic [7:0]                  rdata
);
    import main_pkg::*;

    logic [7:0] mem [2**RAM_AW];

    always_ff @(posedge clk) begin
        if (ram_cs) begin
            if (ram_we) mem[addr] <= wdata;
            rdata <= mem[addr];   // old data on a write
        end
    end

endmodule

//--- hw/prot_math.sv
// ###################
// protection chip: 16-bit divider with byte-wide operand registers
// write a and b, then read quotient and remainder bytes
// ###################
`timescale 1ns/10ps

module prot_math (
    input  logic       clk,
    input  logic       rst,
    input  logic       prot_cs,
    input  logic       prot_we,
    input  logic [2:0] addr,
    input  logic [7:0] wdata,
    output logic [7:0] rdata
);
    import board_pkg::*;

    prot_word_u  a, b;        // dividend, divisor
    logic [15:0] quot, rem;

    always_ff @(posedge clk) begin
        if (rst) begin
            a.word <= '0;
            b.word <= '0;
        end else if (prot_cs && prot_we) begin
            case (addr)
                3'd0: a.bytes.hi <= wdata;
                3'd1: a.bytes.lo <= wdata;
                3'd2: b.bytes.hi <= wdata;
                3'd3: b.bytes.lo <= wdata;
                default: ;   // no register here
            endcase
        end
    end

    // divide by zero saturates the quotient and passes a through
    always_comb begin
        if (b.word == 16'd0) begin
            quot = 16'hffff;
            rem  = a.word;
        end else begin
            quot = a.word / b.word;
            rem  = a.word % b.word;
        end
    end

    always_ff @(posedge clk) begin
        if (prot_cs && !prot_we) begin
            case (addr)
                3'd0:    rdata <= quot[15:8];
                3'd1:    rdata <= quot[7:0];
                3'd2:    rdata <= rem[15:8];
                3'd3:    rdata <= rem[7:0];
                default: rdata <= 8'hff;
            endcase
        end
    end

    a_no_cs_in_rst: assert property (@(posedge clk) rst |-> !prot_cs);

endmodule

//--- test/main_board_tb.sv
// ####################
// testbench for the main CPU bus side of the board
// plays the bus master, ROM and video devices, and checks every
// response against a model of RAM, bank, protection chip and video
// ####################
`timescale 1ns/10ps

module main_board_tb;
    import main_pkg::*;
    import board_pkg::*;

    localparam int N_RANDOM   = 600;
    localparam int N_DIRECTED = 40;
    localparam int WATCHDOG_CYCLES = 400 * (N_RANDOM + N_DIRECTED);

    logic              clk, rst;
    logic              req_valid, req_ready, rsp_valid, rsp_ready;
    bus_req_t          req;
    bus_rsp_t          rsp;
    logic              rom_cs, rom_ok, vid_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic [7:0]        rom_data, vid_dout;
    vid_req_t          vid;
    cab_in_t           cab;
    logic              vblank, pause, irq_ack, irq_n;

    integer            seed = 25564;
    int                cycle;
    logic [7:0]        ram_m [2**RAM_AW];
    logic [2**RAM_AW-1:0] ram_set;   // RAM bytes written so far
    logic [7:0]        vid_m [2**14];  // indexed by {pal, addr}
    logic [BANK_W-1:0] bank_m;
    prot_word_u        a_m, b_m;
    cab_in_t           cab_m;

    tb_clock tb_clock_inst (.clk(clk));

    main_board main_board_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .vid_cs    (vid_cs),
        .vid       (vid),
        .vid_dout  (vid_dout),
        .cab       (cab),
        .vblank    (vblank),
        .pause     (pause),
        .irq_ack   (irq_ack),
        .irq_n     (irq_n)
    );

    always @(posedge clk) begin
        if (rst) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input logic [15:0] addr);
        if (got !== exp) begin
            fail_run($sformatf("Error rsp.rdata at addr %04h: got %02h, expected %02h",
                               addr, got.rdata, exp.rdata));
        end
    endtask

    task automatic check_rom_addr(input logic [ROM_AW-1:0] got, input logic [ROM_AW-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error rom_addr: got %05h, expected %05h", got, exp));
        end
    endtask

    task automatic check_vid(input vid_req_t got, input vid_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error vid: got %06h, expected %06h", got, exp));
        end
    endtask

    task automatic check_irq_n(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error irq_n: got %0h, expected %0h", got, exp));
        end
    endtask

    function automatic logic [7:0] rom_byte(logic [ROM_AW-1:0] a);
        return (a[7:0] ^ a[15:8]) + {a[16], 7'h2d};
    endfunction

    function automatic logic [7:0] vid_fill(logic [13:0] a);
        return a[13:6] ^ a[7:0] ^ 8'h5c;
    endfunction

    // address map as the board documents it
    function automatic region_e region_of(bus_req_t r);
        logic [15:0] a;
        a = r.addr;
        if (a >= 16'h4000) return r.rnw ? reg_rom : reg_none;
        if (a >= 16'h2000) return reg_gfx;
        if (a >= 16'h1800) return reg_ram;
        if (a >= 16'h1000) return reg_pal;
        if (a < 16'h0100) return reg_cfg;
        case (a[15:8])
            8'h0a:   return r.rnw ? reg_cab : reg_none;
            8'h0b:   return r.rnw ? reg_sys : reg_none;
            8'h0c:   return r.rnw ? reg_none : reg_bank;
            8'h0d:   return reg_prot;
            default: return reg_none;
        endcase
    endfunction

    // fixed window at the bottom of the ROM, banked 8 KB pages from 0x08000
    function automatic logic [ROM_AW-1:0] rom_addr_of(logic [15:0] a);
        int unsigned off;
        if (a >= 16'h8000) begin
            off = 32'(a) - 32'h8000;
        end else begin
            off = (32'(bank_m) + 32'd4) * 32'h2000 + 32'(a) % 32'h2000;
        end
        return off[ROM_AW-1:0];
    endfunction

    function automatic vid_req_t vid_of(bus_req_t r);
        vid_req_t    v;
        region_e     g;
        int unsigned off;
        g = region_of(r);
        v.pal = g == reg_pal;
        v.we = !r.rnw;
        v.wdata = r.wdata;
        case (g)
            reg_cfg: off = 32'h1000 + 32'(r.addr[7:0]);
            reg_gfx: off = (32'(r.addr) - 32'h2000) ^ 32'h1000;   // upper 4 KB first
            default: off = 32'(r.addr) % 32'h800;
        endcase
        v.addr = off[12:0];
        return v;
    endfunction

    function automatic logic [7:0] prot_read(logic [2:0] off);
        logic [15:0] q, m;
        if (b_m.word == 16'd0) begin
            q = 16'hffff;
            m = a_m.word;
        end else begin
            q = a_m.word / b_m.word;
            m = a_m.word % b_m.word;
        end
        case (off)
            3'd0:    return q[15:8];
            3'd1:    return q[7:0];
            3'd2:    return m[15:8];
            3'd3:    return m[7:0];
            default: return 8'hff;
        endcase
    endfunction

    function automatic bus_rsp_t predict(bus_req_t r);
        bus_rsp_t   p;
        vid_req_t   v;
        logic [5:0] j;
        v = vid_of(r);
        j = r.addr[0] ? cab_m.joy1 : cab_m.joy2;
        p.rdata = 8'hff;
        if (r.rnw) begin
            case (region_of(r))
                reg_rom: p.rdata = rom_byte(rom_addr_of(r.addr));
                reg_ram: p.rdata = ram_m[r.addr[10:0]];
                reg_pal, reg_gfx, reg_cfg: p.rdata = vid_m[{v.pal, v.addr}];
                reg_cab: p.rdata = {2'b11, j[5:4], j[2], j[3], j[0], j[1]};
                reg_sys: begin
                    case (r.addr[1:0])
                        2'd0:    p.rdata = {3'b111, cab_m.start, cab_m.service, cab_m.coin};
                        2'd1:    p.rdata = cab_m.dipsw_a;
                        2'd2:    p.rdata = cab_m.dipsw_b;
                        default: p.rdata = 8'hff;
                    endcase
                end
                reg_prot: p.rdata = prot_read(r.addr[2:0]);
                default: ;
            endcase
        end
        return p;
    endfunction

    function automatic void update_model(bus_req_t r);
        vid_req_t v;
        v = vid_of(r);
        if (!r.rnw) begin
            case (region_of(r))
                reg_ram: begin
                    ram_m[r.addr[10:0]] = r.wdata;
                    ram_set[r.addr[10:0]] = 1'b1;
                end
                reg_bank: bank_m = r.wdata[BANK_W-1:0];
                reg_prot: begin
                    case (r.addr[2:0])
                        3'd0:    a_m.bytes.hi = r.wdata;
                        3'd1:    a_m.bytes.lo = r.wdata;
                        3'd2:    b_m.bytes.hi = r.wdata;
                        3'd3:    b_m.bytes.lo = r.wdata;
                        default: ;
                    endcase
                end
                reg_pal, reg_gfx, reg_cfg: vid_m[{v.pal, v.addr}] = r.wdata;
                default: ;
            endcase
        end
    endfunction

    // one access from request to taken response, also serving ROM and video
    task automatic run_access(input bus_req_t r, input bit stall);
        bus_rsp_t          exp_rsp, held;
        vid_req_t          v;
        logic [ROM_AW-1:0] exp_rom;
        logic [31:0]       rnd;
        logic              is_vid, is_rom, s_rom_cs, s_rom_ok, pending, done;
        int                t_acc, t_ok, rom_wait, rom_cnt;
        v = vid_of(r);
        is_rom = region_of(r) == reg_rom;
        is_vid = region_of(r) inside {reg_pal, reg_gfx, reg_cfg};
        exp_rsp = predict(r);
        exp_rom = rom_addr_of(r.addr);
        rnd = $random(seed);
        rom_wait = int'(rnd[2:0]);   // 0 to 7 cycles
        rom_cnt = 0;
        t_ok = 0;
        pending = 1'b0;
        done = 1'b0;
        req_valid <= 1'b1;
        req <= r;
        cab <= cab_m;
        rsp_ready <= 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(posedge clk);
            @(negedge clk);
        end
        if (vid_cs !== is_vid) fail_run("video strobe does not match the decoded region");
        if (is_vid) check_vid(vid, v);
        t_acc = cycle;
        @(posedge clk);
        req_valid <= 1'b0;
        if (is_vid) vid_dout <= vid_m[{v.pal, v.addr}];
        update_model(r);
        while (!done) begin
            @(negedge clk);
            if (req_ready) fail_run("req_ready high while an access is in flight");
            s_rom_cs = rom_cs;
            s_rom_ok = rom_ok;
            if (vid_cs) fail_run("video strobe held past the acceptance cycle");
            if (cycle == t_acc + 1 && s_rom_cs !== is_rom) begin
                fail_run("ROM select not raised the cycle after acceptance");
            end
            if (s_rom_cs && !is_rom) fail_run("ROM select raised for a non-ROM access");
            if (s_rom_cs) check_rom_addr(rom_addr, exp_rom);
            if (s_rom_cs && s_rom_ok) t_ok = cycle;
            if (pending) begin
                if (!rsp_valid) fail_run("response dropped before it was taken");
                check_rsp(rsp, held, r.addr);
            end else if (rsp_valid) begin
                if (is_rom && cycle != t_ok + 1) begin
                    fail_run("ROM response not one cycle after rom_ok");
                end
                if (!is_rom && cycle != t_acc + 2) begin
                    fail_run($sformatf("response came %0d cycles after acceptance", cycle - t_acc));
                end
                check_rsp(rsp, exp_rsp, r.addr);
                held = rsp;
                pending = 1'b1;
            end
            done = rsp_valid && rsp_ready;
            @(posedge clk);
            rnd = $random(seed);
            rsp_ready <= stall ? rnd[0] : 1'b1;
            if (s_rom_cs && s_rom_ok) begin
                rom_ok <= 1'b0;
            end else if (s_rom_cs) begin
                if (rom_cnt == rom_wait) begin
                    rom_ok <= 1'b1;
                    rom_data <= rom_byte(rom_addr);
                end
                rom_cnt++;
            end
        end
    endtask

    task automatic single_access(input logic [15:0] a, input logic [7:0] d, input logic rnw,
                                 input bit stall);
        bus_req_t r;
        r.addr = a;
        r.wdata = d;
        r.rnw = rnw;
        run_access(r, stall);
    endtask

    task automatic random_access();
        bus_req_t    r;
        logic [31:0] rnd, rnd2, rnd3;
        rnd = $random(seed);
        rnd2 = $random(seed);
        rnd3 = $random(seed);
        r.addr = rnd[15:0];
        r.wdata = rnd[23:16];
        r.rnw = rnd[24];
        case (rnd2[3:0])
            4'd0, 4'd1, 4'd2: r.addr = {5'b00011, rnd[10:0]};
            4'd3: r.addr = {1'b1, rnd[14:0]};
            4'd4: r.addr = {2'b01, rnd[13:0]};
            4'd5: r.addr = {8'h0c, rnd[7:0]};
            4'd6: r.addr = {8'h0a, rnd[7:0]};
            4'd7: r.addr = {8'h0b, rnd[7:0]};
            4'd8, 4'd9: r.addr = {8'h0d, rnd[7:0]};
            4'd10: r.addr = {5'b00010, rnd[10:0]};
            4'd11: r.addr = {3'b001, rnd[12:0]};
            4'd12: r.addr = {8'h00, rnd[7:0]};
            4'd13: r.addr = {5'b00001, rnd[10:0]};   // I/O pages, ignored ones too
            default: ;
        endcase
        if (rnd2[3:0] inside {4'd3, 4'd4, 4'd6, 4'd7}) r.rnw = 1'b1;
        if (rnd2[3:0] == 4'd5) r.rnw = 1'b0;
        if (r.addr[15:11] == 5'b00011 && r.rnw && !ram_set[r.addr[10:0]]) begin
            r.rnw = 1'b0;   // no reads of unwritten RAM
        end
        cab_m = {rnd3, rnd2[31]};
        if (rnd3[8]) @(posedge clk);
        run_access(r, rnd2[4]);
    endtask

    task automatic bank_sweep();
        single_access(16'h5abc, 8'h00, 1'b1, 1'b0);   // bank 0 out of reset
        for (int i = 0; i < 8; i++) begin
            single_access(16'h0c00, {5'b10101, i[2:0]}, 1'b0, 1'b0);
            single_access({2'b01, i[2:0], 11'h155}, 8'h00, 1'b1, 1'b0);
        end
        single_access(16'hc3a5, 8'h00, 1'b1, 1'b0);
    endtask

    task automatic prot_directed();
        single_access(16'h0d00, 8'h12, 1'b0, 1'b0);
        single_access(16'h0d01, 8'h34, 1'b0, 1'b0);
        single_access(16'h0d02, 8'h00, 1'b0, 1'b0);
        single_access(16'h0d03, 8'h00, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            single_access({13'h01a0, i[2:0]}, 8'h00, 1'b1, 1'b1);   // divide by zero
        end
        single_access(16'h0d03, 8'h07, 1'b0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            single_access({13'h01a0, i[2:0]}, 8'h00, 1'b1, 1'b1);
        end
    endtask

    task automatic irq_test();
        pause <= 1'b0;
        vblank <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_irq_n(irq_n, 1'b0);
        @(posedge clk);
        irq_ack <= 1'b1;
        @(posedge clk);
        irq_ack <= 1'b0;
        @(negedge clk);
        check_irq_n(irq_n, 1'b1);
        @(posedge clk);
        vblank <= 1'b0;
        pause <= 1'b1;
        @(posedge clk);
        vblank <= 1'b1;   // edge while paused
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_irq_n(irq_n, 1'b1);
        @(posedge clk);
        vblank <= 1'b0;
        pause <= 1'b0;
        @(posedge clk);
        vblank <= 1'b1;
        irq_ack <= 1'b1;
        @(posedge clk);
        irq_ack <= 1'b0;
        @(negedge clk);
        check_irq_n(irq_n, 1'b1);   // ack wins over a new edge
        @(posedge clk);
        vblank <= 1'b0;
    endtask

    initial begin
        rst <= 1'b1;
        req_valid <= 1'b0;
        req <= '0;
        rsp_ready <= 1'b0;
        rom_ok <= 1'b0;
        rom_data <= 8'h00;
        vid_dout <= 8'h00;
        cab <= '0;
        vblank <= 1'b0;
        pause <= 1'b0;
        irq_ack <= 1'b0;
        cab_m = '0;
        bank_m = '0;
        a_m.word = 16'd0;
        b_m.word = 16'd0;
        ram_set = '0;
        for (int i = 0; i < 2**14; i++) begin
            vid_m[i[13:0]] = vid_fill(i[13:0]);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!req_ready || rsp_valid || rom_cs || vid_cs) begin
            fail_run("bus handshake not idle after reset");
        end
        check_irq_n(irq_n, 1'b1);
        @(posedge clk);
        bank_sweep();
        prot_directed();
        repeat (N_RANDOM) random_access();
        irq_test();
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

//--- test/tb_clock.sv
// ####################
// free-running testbench clock, 20 ns period
// ####################
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;   // 50 MHz

endmodule

//--- vlog.f
common/main_pkg.sv
common/board_pkg.sv
hw/main_bus/work_ram.sv
hw/main_bus/main_bus.sv
hw/cabinet_io.sv
hw/prot_math.sv
hw/main_board.sv
test/tb_clock.sv
test/main_board_tb.sv
